/* rtl/clk_div.sv */
`default_nettype none
`timescale 1ns/1ps

// Free-running divider, one-cycle tick every DIV clocks
module clk_div #(
    parameter int WIDTH = 4,
    parameter int DIV   = 16
) (
    input  wire  clk,
    input  wire  rst,
    output logic tick
);

    // Terminal count
    localparam logic [WIDTH-1:0] LAST = WIDTH'(DIV - 1);

    logic [WIDTH-1:0] cnt;

    // Tick marks the wrap cycle
    assign tick = (cnt == LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (tick) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/gb_io_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Register map and peripheral encodings
////////////////////////////////////////////////////////////////////////////

package gb_io_pkg;

    // Full 16-bit addresses of the mapped registers
    typedef enum logic [15:0] {
        REG_SB   = 16'hFF01,
        REG_SC   = 16'hFF02,
        REG_DIV  = 16'hFF04,
        REG_TIMA = 16'hFF05,
        REG_TMA  = 16'hFF06,
        REG_TAC  = 16'hFF07,
        REG_IF   = 16'hFF0F,
        REG_IE   = 16'hFFFF
    } io_reg_e;

    // Serial shift engine
    typedef enum logic {
        SER_IDLE  = 1'b0,
        SER_SHIFT = 1'b1
    } serial_state_e;

    // TAC bits 1:0
    // Period of each code comes from the settings header
    typedef enum logic [1:0] {
        TAC_P0 = 2'd0,
        TAC_P1 = 2'd1,
        TAC_P2 = 2'd2,
        TAC_P3 = 2'd3
    } tac_rate_e;

endpackage

`default_nettype wire

/* rtl/gb_io_settings.svh */
`ifndef GB_IO_SETTINGS_SVH
`define GB_IO_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Clock ratios for the I/O block
////////////////////////////////////////////////////////////////////////////

// Clocks per serial bit tick
`define GB_SERIAL_DIV 16

// Clocks per DIV register step
`define GB_DIV_TICK 64

// Clocks per TIMA step, indexed by TAC rate code
`define GB_TIMA_P0 256
`define GB_TIMA_P1 16
`define GB_TIMA_P2 64
`define GB_TIMA_P3 128

`endif

/* rtl/gb_irq_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Interrupt sources
////////////////////////////////////////////////////////////////////////////

package gb_irq_pkg;

    // Bit position in IF and IE, lowest number wins
    typedef enum logic [2:0] {
        IRQ_VBLANK = 3'd0,
        IRQ_STAT   = 3'd1,
        IRQ_TIMER  = 3'd2,
        IRQ_SERIAL = 3'd3,
        IRQ_JOYPAD = 3'd4
    } irq_src_e;

    // One flag per source
    typedef logic [4:0] irq_vec_t;

endpackage

`default_nettype wire

/* rtl/io_bus_if.sv */
`default_nettype none
`timescale 1ns/1ps

// One peripheral's view of the CPU register bus
interface io_bus_if;

    logic       sel;      // address falls in this peripheral
    logic [3:0] addr_lo;
    logic [7:0] wdata;
    logic       wr;
    logic       rd;
    logic [7:0] rdata;    // combinational, FF when not selected

    // Decoder side
    modport master (output sel, output addr_lo, output wdata,
                    output wr, output rd, input rdata);

    // Register block side
    modport slave (input sel, input addr_lo, input wdata,
                   input wr, input rd, output rdata);

endinterface

`default_nettype wire

/* rtl/io_decoder.sv */
`default_nettype none
`timescale 1ns/1ps

// Address decode and read return
module io_decoder (
    input  wire  [15:0] a,
    input  wire  [7:0]  din,
    input  wire         rd,
    input  wire         wr,
    output logic [7:0]  dout,
    io_bus_if.master    ser,
    io_bus_if.master    tmr,
    io_bus_if.master    irq
);

    logic hit_ser;
    logic hit_tmr;
    logic hit_irq;

    // Register ranges
    assign hit_ser = a inside {[gb_io_pkg::REG_SB : gb_io_pkg::REG_SC]};
    assign hit_tmr = a inside {[gb_io_pkg::REG_DIV : gb_io_pkg::REG_TAC]};
    assign hit_irq = a inside {gb_io_pkg::REG_IF, gb_io_pkg::REG_IE};

    // Serial
    assign ser.sel     = hit_ser;
    assign ser.addr_lo = a[3:0];
    assign ser.wdata   = din;
    assign ser.wr      = wr;
    assign ser.rd      = rd;

    // Timer
    assign tmr.sel     = hit_tmr;
    assign tmr.addr_lo = a[3:0];
    assign tmr.wdata   = din;
    assign tmr.wr      = wr;
    assign tmr.rd      = rd;

    // IF and IE share low nibble F
    // Bit 3 carries a[7] so IE stays apart
    assign irq.sel     = hit_irq;
    assign irq.addr_lo = {a[7], a[2:0]};
    assign irq.wdata   = din;
    assign irq.wr      = wr;
    assign irq.rd      = rd;

    // Unmapped reads FF
    always_comb begin
        if (hit_ser) begin
            dout = ser.rdata;
        end else if (hit_tmr) begin
            dout = tmr.rdata;
        end else if (hit_irq) begin
            dout = irq.rdata;
        end else begin
            dout = 8'hFF;
        end
    end

endmodule

`default_nettype wire

/* rtl/io_subsystem.sv */
`default_nettype none
`timescale 1ns/1ps

// I/O register block top level
module io_subsystem (
    input  wire         clk,
    input  wire         rst,
    // CPU register bus
    input  wire  [15:0] a,
    input  wire  [7:0]  din,
    input  wire         rd,
    input  wire         wr,
    output logic [7:0]  dout,
    // Link cable
    input  wire         serial_in,
    output logic        serial_out,
    output logic        serial_clk,
    // vblank, stat, joypad pulses
    input  wire  [2:0]  ext_evt,
    // Interrupt request toward the CPU
    output logic        irq_valid,
    output logic [2:0]  irq_id,
    input  wire         irq_ack
);

    logic timer_evt;
    logic serial_evt;

    // Per-peripheral bus slices
    io_bus_if ser_bus ();
    io_bus_if tmr_bus ();
    io_bus_if irq_bus ();

    io_decoder u_dec (
        .a    (a),
        .din  (din),
        .rd   (rd),
        .wr   (wr),
        .dout (dout),
        .ser  (ser_bus.master),
        .tmr  (tmr_bus.master),
        .irq  (irq_bus.master)
    );

    serial_port u_ser (
        .clk        (clk),
        .rst        (rst),
        .bus        (ser_bus.slave),
        .serial_in  (serial_in),
        .serial_out (serial_out),
        .serial_clk (serial_clk),
        .serial_evt (serial_evt)
    );

    timer_unit u_tmr (
        .clk       (clk),
        .rst       (rst),
        .bus       (tmr_bus.slave),
        .timer_evt (timer_evt)
    );

    // Enum id leaves as a plain 3-bit code
    irq_ctrl u_irq (
        .clk        (clk),
        .rst        (rst),
        .bus        (irq_bus.slave),
        .timer_evt  (timer_evt),
        .serial_evt (serial_evt),
        .ext_evt    (ext_evt),
        .irq_valid  (irq_valid),
        .irq_id     (irq_id),
        .irq_ack    (irq_ack)
    );

endmodule

`default_nettype wire

/* rtl/irq_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

// IF/IE and CPU interrupt request
module irq_ctrl (
    input  wire                   clk,
    input  wire                   rst,
    io_bus_if.slave               bus,
    input  wire                   timer_evt,
    input  wire                   serial_evt,
    input  wire  [2:0]            ext_evt,
    output logic                  irq_valid,
    output gb_irq_pkg::irq_src_e  irq_id,
    input  wire                   irq_ack
);

    gb_irq_pkg::irq_vec_t if_reg;
    gb_irq_pkg::irq_vec_t ie_reg;
    gb_irq_pkg::irq_vec_t evt_vec;
    gb_irq_pkg::irq_vec_t pending;
    gb_irq_pkg::irq_vec_t ack_mask;
    gb_irq_pkg::irq_src_e sel_id;
    gb_irq_pkg::irq_src_e held_id;
    logic                 held;
    logic                 wr_if;
    logic                 wr_ie;
    logic                 take;

    // Address bit 3 set only for IE on this bus
    assign wr_ie = bus.sel && bus.wr && bus.addr_lo[3];
    assign wr_if = bus.sel && bus.wr && !bus.addr_lo[3];

    // Event pulses into IF bit positions
    always_comb begin
        evt_vec = '0;
        evt_vec[gb_irq_pkg::IRQ_VBLANK] = ext_evt[0];
        evt_vec[gb_irq_pkg::IRQ_STAT]   = ext_evt[1];
        evt_vec[gb_irq_pkg::IRQ_TIMER]  = timer_evt;
        evt_vec[gb_irq_pkg::IRQ_SERIAL] = serial_evt;
        evt_vec[gb_irq_pkg::IRQ_JOYPAD] = ext_evt[2];
    end

    assign pending = if_reg & ie_reg;

    // Lowest enabled bit wins
    always_comb begin
        sel_id = gb_irq_pkg::IRQ_VBLANK;
        for (int i = 4; i >= 0; i--) begin
            if (pending[i]) begin
                sel_id = gb_irq_pkg::irq_src_e'(3'(i));
            end
        end
    end

    // Request frozen once offered and not yet taken
    assign irq_valid = held || (|pending);
    assign irq_id    = held ? held_id : sel_id;
    assign take      = irq_valid && irq_ack;

    always_comb begin
        ack_mask = '0;
        if (take) begin
            ack_mask[irq_id] = 1'b1;
        end
    end

    always_comb begin
        bus.rdata = 8'hFF;
        if (bus.sel && bus.rd) begin
            bus.rdata = bus.addr_lo[3] ? {3'b111, ie_reg} : {3'b111, if_reg};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Flag registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_reg <= '0;
            ie_reg <= '0;
            held   <= 1'b0;
        end else begin
            if (wr_ie) begin
                ie_reg <= bus.wdata[4:0];
            end
            // New events survive a CPU write or an ack
            if (wr_if) begin
                if_reg <= bus.wdata[4:0] | evt_vec;
            end else begin
                if_reg <= (if_reg & ~ack_mask) | evt_vec;
            end
            held <= irq_valid && !irq_ack;
        end
    end

    // Id seen by the CPU while waiting
    always_ff @(posedge clk) begin
        held_id <= irq_id;
    end

endmodule

`default_nettype wire

/* rtl/serial_port.sv */
`default_nettype none
`timescale 1ns/1ps
`include "gb_io_settings.svh"

// Serial link port, internal clock only
module serial_port (
    input  wire        clk,
    input  wire        rst,
    io_bus_if.slave    bus,
    input  wire        serial_in,
    output logic       serial_out,
    output logic       serial_clk,
    output logic       serial_evt
);

    localparam int TICK_W = $clog2(`GB_SERIAL_DIV + 1);

    gb_io_pkg::serial_state_e state;

    logic       bit_tick;
    logic [7:0] sb;
    logic       sc_start;   // SC bit 7, transfer busy
    logic       sc_int;     // SC bit 0, internal clock
    logic [2:0] bit_cnt;
    logic       wr_sb;
    logic       wr_sc;
    logic       abort;
    logic       shift_step;

    // Bit rate
    clk_div #(
        .WIDTH (TICK_W),
        .DIV   (`GB_SERIAL_DIV)
    ) u_bit_div (
        .clk  (clk),
        .rst  (rst),
        .tick (bit_tick)
    );

    assign wr_sb = bus.sel && bus.wr && (bus.addr_lo == 4'(gb_io_pkg::REG_SB));
    assign wr_sc = bus.sel && bus.wr && (bus.addr_lo == 4'(gb_io_pkg::REG_SC));

    // Clearing SC bit 7 mid transfer stops the engine
    assign abort      = (state == gb_io_pkg::SER_SHIFT) && wr_sc && !bus.wdata[7];
    assign shift_step = (state == gb_io_pkg::SER_SHIFT) && bit_tick && !abort;

    // Done on the eighth rising edge
    assign serial_evt = shift_step && (bit_cnt == 3'd7);

    // Read mux, idle bus reads high
    always_comb begin
        bus.rdata = 8'hFF;
        if (bus.sel && bus.rd) begin
            case (bus.addr_lo)
                4'(gb_io_pkg::REG_SB): bus.rdata = sb;
                4'(gb_io_pkg::REG_SC): bus.rdata = {sc_start, 6'h3F, sc_int};
                default:               bus.rdata = 8'hFF;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Shift engine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= gb_io_pkg::SER_IDLE;
            sb         <= 8'h00;
            sc_start   <= 1'b0;
            sc_int     <= 1'b0;
            bit_cnt    <= 3'd0;
            serial_clk <= 1'b1;
            serial_out <= 1'b1;
        end else begin
            if (wr_sb) begin
                sb <= bus.wdata;
            end
            if (wr_sc) begin
                sc_start <= bus.wdata[7];
                sc_int   <= bus.wdata[0];
            end
            case (state)
                gb_io_pkg::SER_IDLE: begin
                    // Line parked high
                    serial_clk <= 1'b1;
                    serial_out <= 1'b1;
                    if (wr_sc && bus.wdata[7] && bus.wdata[0]) begin
                        // First falling edge right at the start write
                        state      <= gb_io_pkg::SER_SHIFT;
                        bit_cnt    <= 3'd0;
                        serial_clk <= 1'b0;
                        serial_out <= sb[7];
                    end
                end
                gb_io_pkg::SER_SHIFT: begin
                    if (abort) begin
                        state      <= gb_io_pkg::SER_IDLE;
                        serial_clk <= 1'b1;
                    end else if (shift_step) begin
                        // Rising edge, sample and shift
                        serial_clk <= 1'b1;
                        sb         <= {sb[6:0], serial_in};
                        bit_cnt    <= bit_cnt + 3'd1;
                        if (serial_evt) begin
                            state    <= gb_io_pkg::SER_IDLE;
                            sc_start <= 1'b0;
                        end
                    end else if (serial_clk) begin
                        // Falling edge one cycle later, next MSB out
                        serial_clk <= 1'b0;
                        serial_out <= sb[7];
                    end
                end
                default: state <= gb_io_pkg::SER_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/timer_unit.sv */
`default_nettype none
`timescale 1ns/1ps
`include "gb_io_settings.svh"

// DIV and TIMA timer
module timer_unit (
    input  wire        clk,
    input  wire        rst,
    io_bus_if.slave    bus,
    output logic       timer_evt
);

    // Terminal counts
    localparam logic [15:0] DIV_LAST = 16'(`GB_DIV_TICK - 1);
    localparam logic [15:0] P0_LAST  = 16'(`GB_TIMA_P0 - 1);
    localparam logic [15:0] P1_LAST  = 16'(`GB_TIMA_P1 - 1);
    localparam logic [15:0] P2_LAST  = 16'(`GB_TIMA_P2 - 1);
    localparam logic [15:0] P3_LAST  = 16'(`GB_TIMA_P3 - 1);

    logic [15:0] div_pre;
    logic [15:0] rate_cnt;
    logic [15:0] rate_last;
    logic [7:0]  div_reg;
    logic [7:0]  tima;
    logic [7:0]  tma;
    logic [2:0]  tac;
    logic        wr_div;
    logic        wr_tima;
    logic        wr_tma;
    logic        wr_tac;
    logic        tima_step;
    logic        tima_ovf;

    assign wr_div  = bus.sel && bus.wr && (bus.addr_lo == 4'(gb_io_pkg::REG_DIV));
    assign wr_tima = bus.sel && bus.wr && (bus.addr_lo == 4'(gb_io_pkg::REG_TIMA));
    assign wr_tma  = bus.sel && bus.wr && (bus.addr_lo == 4'(gb_io_pkg::REG_TMA));
    assign wr_tac  = bus.sel && bus.wr && (bus.addr_lo == 4'(gb_io_pkg::REG_TAC));

    // Period select from TAC rate code
    always_comb begin
        case (gb_io_pkg::tac_rate_e'(tac[1:0]))
            gb_io_pkg::TAC_P0: rate_last = P0_LAST;
            gb_io_pkg::TAC_P1: rate_last = P1_LAST;
            gb_io_pkg::TAC_P2: rate_last = P2_LAST;
            gb_io_pkg::TAC_P3: rate_last = P3_LAST;
            default:           rate_last = P0_LAST;
        endcase
    end

    assign tima_step = tac[2] && (rate_cnt == rate_last);
    assign tima_ovf  = tima_step && (tima == 8'hFF);

    // CPU write to TIMA in the overflow cycle cancels the event
    assign timer_evt = tima_ovf && !wr_tima;

    always_comb begin
        bus.rdata = 8'hFF;
        if (bus.sel && bus.rd) begin
            case (bus.addr_lo)
                4'(gb_io_pkg::REG_DIV):  bus.rdata = div_reg;
                4'(gb_io_pkg::REG_TIMA): bus.rdata = tima;
                4'(gb_io_pkg::REG_TMA):  bus.rdata = tma;
                4'(gb_io_pkg::REG_TAC):  bus.rdata = {5'h1F, tac};
                default:                 bus.rdata = 8'hFF;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Counters
    ////////////////////////////////////////////////////////////////////////////

    // DIV and its prescaler, any write zeroes both
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_pre <= 16'h0000;
            div_reg <= 8'h00;
        end else if (wr_div) begin
            div_pre <= 16'h0000;
            div_reg <= 8'h00;
        end else if (div_pre == DIV_LAST) begin
            div_pre <= 16'h0000;
            div_reg <= div_reg + 8'd1;
        end else begin
            div_pre <= div_pre + 16'd1;
        end
    end

    // Rate counter restarts on TAC write and parks while stopped
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rate_cnt <= 16'h0000;
        end else if (wr_tac || !tac[2] || tima_step) begin
            rate_cnt <= 16'h0000;
        end else begin
            rate_cnt <= rate_cnt + 16'd1;
        end
    end

    // TIMA, TMA, TAC
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tima <= 8'h00;
            tma  <= 8'h00;
            tac  <= 3'b000;
        end else begin
            if (wr_tma) begin
                tma <= bus.wdata;
            end
            if (wr_tac) begin
                tac <= bus.wdata[2:0];
            end
            if (wr_tima) begin
                tima <= bus.wdata;
            end else if (tima_ovf) begin
                tima <= tma;    // reload uses TMA before any same-cycle write
            end else if (tima_step) begin
                tima <= tima + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the I/O block testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f sources.f \
    --top-module tb_io_subsystem \
    -o sim_io_subsystem

./obj_dir/sim_io_subsystem > sim.log 2>&1
cat sim.log

if grep -q "^Simulation completed successfully$" sim.log; then
    echo "Result: PASS"
else
    echo "Result: FAIL"
    exit 1
fi

/* sim/tb_io_subsystem.sv */
`default_nettype none
`timescale 1ns/1ps
`include "gb_io_settings.svh"

module tb_io_subsystem;

    // Cycle budget per test group
    localparam int REG_CYCLES = 256;
    localparam int SER_CYCLES = 10 * `GB_SERIAL_DIV + 32;
    localparam int TMR_CYCLES = 3 * `GB_TIMA_P1 + 32;
    localparam int IRQ_CYCLES = SER_CYCLES + TMR_CYCLES + 64;
    localparam int DIV_CYCLES = 3 * `GB_DIV_TICK + 32;
    localparam int WATCHDOG_CYCLES =
        2 * (16 + REG_CYCLES + SER_CYCLES + TMR_CYCLES + IRQ_CYCLES + DIV_CYCLES);
    localparam int RISE_LIMIT = 2 * `GB_SERIAL_DIV + 4;

    logic        clk;
    logic        rst;
    logic [15:0] a;
    logic [7:0]  din;
    logic        rd;
    logic        wr;
    logic [7:0]  dout;
    logic        serial_in;
    logic        serial_out;
    logic        serial_clk;
    logic [2:0]  ext_evt;
    logic        irq_valid;
    logic [2:0]  irq_id;
    logic        irq_ack;

    logic [31:0] rng_state;
    int          checks;
    int          errors;

    io_subsystem dut0 (
        .clk        (clk),
        .rst        (rst),
        .a          (a),
        .din        (din),
        .rd         (rd),
        .wr         (wr),
        .dout       (dout),
        .serial_in  (serial_in),
        .serial_out (serial_out),
        .serial_clk (serial_clk),
        .ext_evt    (ext_evt),
        .irq_valid  (irq_valid),
        .irq_id     (irq_id),
        .irq_ack    (irq_ack)
    );

    // 10 ns period
    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and random source
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [7:0] next_byte();
        rng_state = lcg_step(rng_state);
        return rng_state[23:16];
    endfunction

    // Read value of a register holding v with unused bits high
    function automatic logic [7:0] ref_reg(input logic [15:0] addr, input logic [7:0] v);
        case (addr)
            gb_io_pkg::REG_SB,
            gb_io_pkg::REG_DIV,
            gb_io_pkg::REG_TIMA,
            gb_io_pkg::REG_TMA: return v;
            gb_io_pkg::REG_SC:  return {v[7], 6'h3F, v[0]};
            gb_io_pkg::REG_TAC: return {5'h1F, v[2:0]};
            gb_io_pkg::REG_IF,
            gb_io_pkg::REG_IE:  return {3'b111, v[4:0]};
            default:            return 8'hFF;
        endcase
    endfunction

    // Lowest pending bit wins
    function automatic logic [2:0] ref_irq_id(input logic [4:0] pend);
        for (int i = 0; i < 5; i++) begin
            if (pend[i]) begin
                return 3'(i);
            end
        end
        return 3'd0;
    endfunction

    task automatic check(input logic [7:0] got, input logic [7:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0d ns: %s, got %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus and pin helpers starting and ending 1 ns after an edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        a   = addr;
        din = data;
        wr  = 1'b1;
        wait_cycles(1);
        wr  = 1'b0;
    endtask

    // dout is combinational and sampled mid cycle
    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        a  = addr;
        rd = 1'b1;
        #4;
        data = dout;
        wait_cycles(1);
        rd = 1'b0;
    endtask

    task automatic read_check(input logic [15:0] addr, input logic [7:0] exp,
                              input string what);
        logic [7:0] got;
        bus_read(addr, got);
        check(got, exp, $sformatf("%s at %04h", what, addr));
    endtask

    task automatic wait_serial_rise(output logic seen);
        logic last;
        int   n;
        seen = 1'b0;
        last = serial_clk;
        n    = 0;
        while (!seen && n < RISE_LIMIT) begin
            wait_cycles(1);
            if (serial_clk && !last) begin
                seen = 1'b1;
            end
            last = serial_clk;
            n++;
        end
        if (!seen) begin
            errors++;
            $display("Error at %0d ns: serial_clk never rose during a transfer", $time);
        end
    endtask

    // Poll SC until the busy bit drops
    task automatic wait_sc_done();
        logic [7:0] sc;
        int         n;
        n = 0;
        bus_read(gb_io_pkg::REG_SC, sc);
        while (sc[7] && n < 4 * `GB_SERIAL_DIV) begin
            bus_read(gb_io_pkg::REG_SC, sc);
            n++;
        end
        if (sc[7]) begin
            errors++;
            $display("Error at %0d ns: serial transfer never finished", $time);
        end
    endtask

    // Full transfer with rx bits offered MSB first on each rising serial_clk
    task automatic run_serial(input logic [7:0] tx, input logic [7:0] rx,
                              output logic [7:0] captured);
        logic seen;
        captured = 8'h00;
        bus_write(gb_io_pkg::REG_SB, tx);
        serial_in = rx[7];
        bus_write(gb_io_pkg::REG_SC, 8'h81);
        for (int i = 0; i < 8; i++) begin
            wait_serial_rise(seen);
            if (!seen) begin
                break;
            end
            captured[7-i] = serial_out;
            if (i < 7) begin
                serial_in = rx[6-i];
            end
        end
        wait_sc_done();
    endtask

    task automatic wait_if_bit(input int pos, input int limit);
        logic [7:0] flags;
        int         n;
        n = 0;
        bus_read(gb_io_pkg::REG_IF, flags);
        while (!flags[pos] && n < limit) begin
            bus_read(gb_io_pkg::REG_IF, flags);
            n++;
        end
        if (!flags[pos]) begin
            errors++;
            $display("Error at %0d ns: IF bit %0d was never set", $time, pos);
        end
    endtask

    // Ack every enabled flag in priority order
    task automatic service_irqs(inout logic [4:0] if_model, input logic [4:0] mask);
        logic [2:0] exp_id;
        logic [7:0] flags;
        for (int k = 0; k < 6; k++) begin
            if ((if_model & mask) == 5'b0) begin
                break;
            end
            exp_id = ref_irq_id(if_model & mask);
            check(8'(irq_valid), 8'h01, "irq_valid with enabled flag pending");
            check(8'(irq_id), 8'(exp_id), $sformatf("irq_id for IE %05b", mask));
            irq_ack = 1'b1;
            wait_cycles(1);
            irq_ack = 1'b0;
            if_model[exp_id] = 1'b0;
            bus_read(gb_io_pkg::REG_IF, flags);
            check(flags, ref_reg(gb_io_pkg::REG_IF, 8'(if_model)), "IF after ack");
        end
        check(8'(irq_valid), 8'h00, "irq_valid with nothing enabled pending");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence and compare process
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [7:0]  v;
        logic [7:0]  d;
        logic [7:0]  tx;
        logic [7:0]  rx;
        logic [7:0]  cap;
        logic [7:0]  tma_v;
        logic [15:0] addr;
        logic [4:0]  if_model;
        logic [15:0] unmapped [9];

        clk       = 1'b0;
        rst       = 1'b1;
        a         = 16'h0000;
        din       = 8'h00;
        rd        = 1'b0;
        wr        = 1'b0;
        serial_in = 1'b1;
        ext_evt   = 3'b000;
        irq_ack   = 1'b0;
        rng_state = 32'd42372;
        checks    = 0;
        errors    = 0;
        unmapped  = '{16'h0000, 16'h8000, 16'hFF00, 16'hFF03, 16'hFF08,
                      16'hFF0E, 16'hFF10, 16'hFF80, 16'hFFFE};

        wait_cycles(16);
        rst = 1'b0;

        // Reset values
        check(8'(serial_out), 8'h01, "serial_out idle after reset");
        check(8'(serial_clk), 8'h01, "serial_clk idle after reset");
        check(8'(irq_valid), 8'h00, "irq_valid after reset");
        read_check(gb_io_pkg::REG_SB, ref_reg(gb_io_pkg::REG_SB, 8'h00), "SB reset");
        read_check(gb_io_pkg::REG_SC, ref_reg(gb_io_pkg::REG_SC, 8'h00), "SC reset");
        read_check(gb_io_pkg::REG_DIV, ref_reg(gb_io_pkg::REG_DIV, 8'h00), "DIV reset");
        read_check(gb_io_pkg::REG_TIMA, ref_reg(gb_io_pkg::REG_TIMA, 8'h00), "TIMA reset");
        read_check(gb_io_pkg::REG_TMA, ref_reg(gb_io_pkg::REG_TMA, 8'h00), "TMA reset");
        read_check(gb_io_pkg::REG_TAC, ref_reg(gb_io_pkg::REG_TAC, 8'h00), "TAC reset");
        read_check(gb_io_pkg::REG_IF, ref_reg(gb_io_pkg::REG_IF, 8'h00), "IF reset");
        read_check(gb_io_pkg::REG_IE, ref_reg(gb_io_pkg::REG_IE, 8'h00), "IE reset");

        // Random readback while IF stays clear so IE writes raise nothing
        for (int i = 0; i < 8; i++) begin
            v = next_byte();
            bus_write(gb_io_pkg::REG_SB, v);
            read_check(gb_io_pkg::REG_SB, ref_reg(gb_io_pkg::REG_SB, v), "SB readback");
            v = next_byte();
            bus_write(gb_io_pkg::REG_TMA, v);
            read_check(gb_io_pkg::REG_TMA, ref_reg(gb_io_pkg::REG_TMA, v), "TMA readback");
            v = next_byte();
            bus_write(gb_io_pkg::REG_TAC, v);
            read_check(gb_io_pkg::REG_TAC, ref_reg(gb_io_pkg::REG_TAC, v), "TAC readback");
            v = next_byte();
            bus_write(gb_io_pkg::REG_IE, v);
            read_check(gb_io_pkg::REG_IE, ref_reg(gb_io_pkg::REG_IE, v), "IE readback");
            check(8'(irq_valid), 8'h00, "irq_valid with IE set and IF clear");
        end
        bus_write(gb_io_pkg::REG_TAC, 8'h00);
        bus_write(gb_io_pkg::REG_IE, 8'h00);

        // Unmapped holes and random addresses
        foreach (unmapped[i]) begin
            read_check(unmapped[i], ref_reg(unmapped[i], 8'h00), "unmapped read");
        end
        for (int i = 0; i < 8; i++) begin
            addr = {next_byte(), next_byte()};
            if (!(addr inside {[16'hFF01 : 16'hFF02], [16'hFF04 : 16'hFF07],
                               16'hFF0F, 16'hFFFF})) begin
                read_check(addr, ref_reg(addr, 8'h00), "random unmapped read");
            end
        end

        // Serial loop through the pins
        bus_write(gb_io_pkg::REG_IF, 8'h00);
        tx = next_byte();
        rx = next_byte();
        run_serial(tx, rx, cap);
        check(cap, tx, "bits shifted out on serial_out");
        read_check(gb_io_pkg::REG_SB, rx, "SB after transfer");
        bus_read(gb_io_pkg::REG_IF, d);
        check(d & 8'h08, 8'h08, "IF serial bit after transfer");
        check(8'(serial_clk), 8'h01, "serial_clk idle after transfer");
        check(8'(serial_out), 8'h01, "serial_out idle after transfer");

        // TIMA overflow after two steps of period 16 from FE
        bus_write(gb_io_pkg::REG_IF, 8'h00);
        tma_v = next_byte();
        bus_write(gb_io_pkg::REG_TMA, tma_v);
        bus_write(gb_io_pkg::REG_TIMA, 8'hFE);
        bus_write(gb_io_pkg::REG_TAC, 8'h05);
        wait_cycles(2 * `GB_TIMA_P1 + 4);
        bus_read(gb_io_pkg::REG_IF, d);
        check(d & 8'h04, 8'h04, "IF timer bit after overflow");
        bus_read(gb_io_pkg::REG_TIMA, d);
        check(8'((d == tma_v) || (d == 8'(tma_v + 8'd1))), 8'h01,
              $sformatf("TIMA %02h after reload from TMA %02h", d, tma_v));
        bus_write(gb_io_pkg::REG_TAC, 8'h00);

        // All five sources pending with IE closed
        bus_write(gb_io_pkg::REG_IF, 8'h00);
        ext_evt = 3'b111;
        wait_cycles(1);
        ext_evt = 3'b000;
        bus_write(gb_io_pkg::REG_TMA, 8'h00);
        bus_write(gb_io_pkg::REG_TIMA, 8'hFF);
        bus_write(gb_io_pkg::REG_TAC, 8'h05);
        wait_if_bit(gb_irq_pkg::IRQ_TIMER, 2 * `GB_TIMA_P1);
        bus_write(gb_io_pkg::REG_TAC, 8'h00);
        tx = next_byte();
        rx = next_byte();
        run_serial(tx, rx, cap);
        read_check(gb_io_pkg::REG_IF, 8'hFF, "IF with every source raised");
        check(8'(irq_valid), 8'h00, "irq_valid with IE clear");

        // Two masks and then nothing left
        if_model = 5'h1F;
        bus_write(gb_io_pkg::REG_IE, 8'h16);
        service_irqs(if_model, 5'h16);
        bus_write(gb_io_pkg::REG_IE, 8'h09);
        service_irqs(if_model, 5'h09);
        read_check(gb_io_pkg::REG_IF, 8'hE0, "IF after all acks");

        // DIV rate and then clearing by any write
        bus_write(gb_io_pkg::REG_DIV, next_byte());
        wait_cycles(3 * `GB_DIV_TICK);
        bus_read(gb_io_pkg::REG_DIV, d);
        check(8'((d >= 8'd2) && (d <= 8'd4)), 8'h01,
              $sformatf("DIV reads %02h after three tick periods", d));
        for (int i = 0; i < 2; i++) begin
            wait_cycles(`GB_DIV_TICK);
            bus_write(gb_io_pkg::REG_DIV, next_byte() | 8'h01);
            read_check(gb_io_pkg::REG_DIV, 8'h00, "DIV after write");
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Hung run guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: watchdog expired after %0d cycles, the test sequence is stuck",
                 WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+rtl
rtl/gb_io_pkg.sv
rtl/gb_irq_pkg.sv
rtl/io_bus_if.sv
rtl/clk_div.sv
rtl/serial_port.sv
rtl/timer_unit.sv
rtl/irq_ctrl.sv
rtl/io_decoder.sv
rtl/io_subsystem.sv
sim/tb_io_subsystem.sv
